// File: Makefile
# Verilator build and run of the SSE testbench

VERILATOR ?= verilator
TOP       ?= sse_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv) $(wildcard include/*.svh) $(wildcard verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the verdict
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/fp_add_sub.sv
`include "sse_defines.svh"

module fp_add_sub
	import fp_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  start,
	input  logic  sub,
	input  fp32_t a,
	input  fp32_t b,
	output logic  busy,
	output logic  ready,
	output fp32_t y
);

	localparam int fw = `FP_FRAC_W;
	localparam int mw = fw + 4;    // hidden bit, fraction, guard, round, sticky
	localparam logic [`FP_EXP_W-1:0] exp_ones = `FP_EXP_W'(`FP_EXP_MAX);
	localparam logic [`FP_EXP_W-1:0] max_shift = `FP_EXP_W'(mw);

	typedef enum logic [2:0] {
		as_idle,
		as_check,
		as_add,
		as_norm,
		as_round,
		as_done
	} as_state_t;

	as_state_t state;
	fp32_t a_q, b_q;
	logic sub_q;
	fp_class_t cls_a, cls_b;
	logic sb_eff, eff_sub_w, a_ge_b;
	fp32_t big_op, small_op;
	logic [`FP_EXP_W-1:0] exp_diff, shamt;
	logic [2*mw-1:0] small_wide;
	logic [mw-1:0] small_al;
	logic [mw-1:0] sig_big, sig_small;
	logic [mw:0] sig_r;          // extra top bit catches the carry
	logic signed [9:0] exp_r;
	logic sign_r, eff_sub;
	logic round_up;
	logic [fw+1:0] mant_inc;
	logic signed [9:0] exp_fin;

	assign cls_a = fp_classify(a_q);
	assign cls_b = fp_classify(b_q);
	assign sb_eff = b_q.f.sign ^ sub_q;    // sign of b as it enters the sum
	assign eff_sub_w = a_q.f.sign ^ sb_eff;
	assign a_ge_b = {a_q.f.exp, a_q.f.frac} >= {b_q.f.exp, b_q.f.frac};
	assign big_op = a_ge_b ? a_q : b_q;
	assign small_op = a_ge_b ? b_q : a_q;

	// every bit shifted out during alignment lands in sticky
	assign exp_diff = big_op.f.exp - small_op.f.exp;
	assign shamt = (exp_diff > max_shift) ? max_shift : exp_diff;
	assign small_wide = {1'b1, small_op.f.frac, 3'b000, {mw{1'b0}}} >> shamt;
	assign small_al = {small_wide[2*mw-1:mw+1], small_wide[mw] | (|small_wide[mw-1:0])};

	// nearest even on guard, round and sticky
	assign round_up = sig_r[2] & (sig_r[1] | sig_r[0] | sig_r[3]);
	assign mant_inc = {1'b0, sig_r[mw-1:3]} + {{(fw+1){1'b0}}, round_up};
	assign exp_fin = mant_inc[fw+1] ? exp_r + 10'sd1 : exp_r;

	assign busy = (state != as_idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= as_idle;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;
			case (state)
				as_idle: begin
					if (start) begin
						a_q <= a;
						b_q <= b;
						sub_q <= sub;
						state <= as_check;
					end
				end
				as_check: begin
					state <= as_done;    // special cases skip the datapath
					if (cls_a == fp_nan || cls_b == fp_nan) begin
						y.bits <= `FP_QNAN;
					end else if (cls_a == fp_inf && cls_b == fp_inf) begin
						if (eff_sub_w)
							y.bits <= `FP_QNAN;    // inf - inf
						else
							y <= a_q;
					end else if (cls_a == fp_inf) begin
						y <= a_q;
					end else if (cls_b == fp_inf) begin
						y.f <= '{sb_eff, exp_ones, '0};
					end else if (cls_a == fp_zero && cls_b == fp_zero) begin
						y.f <= '{a_q.f.sign & sb_eff, '0, '0};
					end else if (cls_a == fp_zero) begin
						y.f <= '{sb_eff, b_q.f.exp, b_q.f.frac};
					end else if (cls_b == fp_zero) begin
						y <= a_q;
					end else if (eff_sub_w &&
							{a_q.f.exp, a_q.f.frac} == {b_q.f.exp, b_q.f.frac}) begin
						y.bits <= '0;    // exact cancellation
					end else begin
						sig_big <= {1'b1, big_op.f.frac, 3'b000};
						sig_small <= small_al;
						exp_r <= {2'b00, big_op.f.exp};
						sign_r <= a_ge_b ? a_q.f.sign : sb_eff;
						eff_sub <= eff_sub_w;
						state <= as_add;
					end
				end
				as_add: begin
					if (eff_sub)
						sig_r <= {1'b0, sig_big} - {1'b0, sig_small};
					else
						sig_r <= {1'b0, sig_big} + {1'b0, sig_small};
					state <= as_norm;
				end
				as_norm: begin
					if (sig_r[mw]) begin
						// carry out shifts one step right
						sig_r <= {1'b0, sig_r[mw:2], sig_r[1] | sig_r[0]};
						exp_r <= exp_r + 10'sd1;
						state <= as_round;
					end else if (sig_r[mw-1]) begin
						state <= as_round;
					end else if (exp_r <= 10'sd1) begin
						y.bits <= '0;    // flush what would go subnormal
						state <= as_done;
					end else begin
						sig_r <= sig_r << 1;    // one bit per cycle
						exp_r <= exp_r - 10'sd1;
					end
				end
				as_round: begin
					if (exp_fin >= `FP_EXP_MAX)
						y.f <= '{sign_r, exp_ones, '0};    // overflow saturates to inf
					else
						y.f <= '{sign_r, exp_fin[`FP_EXP_W-1:0], mant_inc[fw-1:0]};
					state <= as_done;
				end
				as_done: begin
					ready <= 1'b1;
					state <= as_idle;
				end
				default: state <= as_idle;
			endcase
		end
	end

endmodule

// File: hdl/fp_pkg.sv
`include "sse_defines.svh"

package fp_pkg;

	typedef struct packed {
		logic                  sign;
		logic [`FP_EXP_W-1:0]  exp;
		logic [`FP_FRAC_W-1:0] frac;
	} fp_fields_t;

	// one float word, seen as raw bits or as its fields
	typedef union packed {
		logic [`FP_EXP_W+`FP_FRAC_W:0] bits;
		fp_fields_t                    f;
	} fp32_t;

	typedef enum logic [2:0] {
		fp_zero,
		fp_normal,
		fp_inf,
		fp_nan
	} fp_class_t;

	// subnormals are treated as zero
	function automatic fp_class_t fp_classify(fp32_t w);
		if (w.f.exp == `FP_EXP_MAX) begin
			return (w.f.frac != '0) ? fp_nan : fp_inf;
		end
		if (w.f.exp == '0) begin
			return fp_zero;
		end
		return fp_normal;
	endfunction

endpackage

// File: hdl/fp_square.sv
`include "sse_defines.svh"

module fp_square
	import fp_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  start,
	input  fp32_t a,
	output logic  busy,
	output logic  ready,
	output fp32_t y
);

	localparam int fw = `FP_FRAC_W;
	localparam int pw = 2 * (fw + 1);    // full significand product
	localparam logic [`FP_EXP_W-1:0] exp_ones = `FP_EXP_W'(`FP_EXP_MAX);

	typedef enum logic [2:0] {
		sq_idle,
		sq_check,
		sq_mul,
		sq_norm,
		sq_round
	} sq_state_t;

	sq_state_t state;
	fp32_t a_q;
	fp_class_t cls_a;
	logic signed [9:0] exp_dbl, exp_r;
	logic [pw-1:0] prod;
	logic [fw-1:0] mant;
	logic guard, sticky;
	logic round_up;
	logic [fw:0] mant_inc;
	logic signed [9:0] exp_fin;

	assign cls_a = fp_classify(a_q);
	// 2e - bias is always odd and never lands on 0 or 254
	assign exp_dbl = $signed({1'b0, a_q.f.exp, 1'b0}) - $signed(10'(`FP_BIAS));

	assign round_up = guard & (sticky | mant[0]);
	assign mant_inc = {1'b0, mant} + {{fw{1'b0}}, round_up};
	assign exp_fin = mant_inc[fw] ? exp_r + 10'sd1 : exp_r;

	assign busy = (state != sq_idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sq_idle;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;
			case (state)
				sq_idle: begin
					if (start) begin
						a_q <= a;
						state <= sq_check;
					end
				end
				sq_check: begin
					exp_r <= exp_dbl;
					if (cls_a == fp_nan) begin
						y.bits <= `FP_QNAN;
						ready <= 1'b1;
						state <= sq_idle;
					end else if (exp_dbl >= `FP_EXP_MAX) begin
						y.f <= '{1'b0, exp_ones, '0};    // inf input or overflow
						ready <= 1'b1;
						state <= sq_idle;
					end else if (exp_dbl < 10'sd1) begin
						y.bits <= '0;    // zero, subnormal or underflow
						ready <= 1'b1;
						state <= sq_idle;
					end else begin
						state <= sq_mul;
					end
				end
				sq_mul: begin
					prod <= {1'b1, a_q.f.frac} * {1'b1, a_q.f.frac};
					state <= sq_norm;
				end
				sq_norm: begin
					if (prod[pw-1]) begin    // product in [2,4)
						mant <= prod[pw-2 -: fw];
						guard <= prod[pw-2-fw];
						sticky <= |prod[pw-3-fw:0];
						exp_r <= exp_r + 10'sd1;
					end else begin
						mant <= prod[pw-3 -: fw];
						guard <= prod[pw-3-fw];
						sticky <= |prod[pw-4-fw:0];
					end
					state <= sq_round;
				end
				sq_round: begin
					// rounding carry may push the exponent over
					if (exp_fin >= `FP_EXP_MAX)
						y.f <= '{1'b0, exp_ones, '0};
					else
						y.f <= '{1'b0, exp_fin[`FP_EXP_W-1:0], mant_inc[fw-1:0]};
					ready <= 1'b1;
					state <= sq_idle;
				end
				default: state <= sq_idle;
			endcase
		end
	end

endmodule

// File: hdl/sse_accum_regs.sv
module sse_accum_regs
	import fp_pkg::*, sse_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        clear,
	input  logic        acc_load,
	input  fp32_t       acc_value,
	output acc_status_t status
);

	always_ff @(posedge clk) begin
		if (rst) begin
			status.sum.bits <= '0;
			status.count <= '0;
		end else if (clear) begin
			status.sum.bits <= '0;    // start a new run
			status.count <= '0;
		end else if (acc_load) begin
			status.sum <= acc_value;
			// hold at the top instead of wrapping
			if (status.count != '1)
				status.count <= status.count + 1'b1;
		end
	end

endmodule

// File: hdl/sse_pkg.sv
`include "sse_defines.svh"

package sse_pkg;

	import fp_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_sub,          // start sample - golden
		st_wait_sub,
		st_square,
		st_wait_square,
		st_acc,          // start square + sum
		st_wait_acc
	} seq_state_t;

	typedef struct packed {
		fp32_t                 sum;
		logic [`SSE_CNT_W-1:0] count;
	} acc_status_t;

endpackage

// File: hdl/sse_sequencer.sv
module sse_sequencer
	import fp_pkg::*, sse_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        sample_valid,
	input  fp32_t       sample,
	input  fp32_t       golden,
	input  acc_status_t status,
	output logic        add_start,
	output logic        add_sub,
	output fp32_t       add_a,
	output fp32_t       add_b,
	input  logic        add_ready,
	input  fp32_t       add_y,
	output logic        sq_start,
	output fp32_t       sq_a,
	input  logic        sq_ready,
	input  fp32_t       sq_y,
	output logic        acc_load,
	output fp32_t       acc_value,
	output logic        busy,
	output logic        ready
);

	seq_state_t state;
	fp32_t sample_q, golden_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;
			case (state)
				st_idle:        if (sample_valid) state <= st_sub;
				st_sub:         state <= st_wait_sub;
				st_wait_sub:    if (add_ready) state <= st_square;
				st_square:      state <= st_wait_square;
				st_wait_square: if (sq_ready) state <= st_acc;
				st_acc:         state <= st_wait_acc;
				st_wait_acc: begin
					if (add_ready) begin
						ready <= 1'b1;    // sum register loads on this edge
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// operands latched only while idle
	always_ff @(posedge clk) begin
		if (state == st_idle && sample_valid) begin
			sample_q <= sample;
			golden_q <= golden;
		end
	end

	assign busy = (state != st_idle);

	// the shared adder subtracts first and accumulates later
	assign add_start = (state == st_sub) || (state == st_acc);
	assign add_sub = (state == st_sub);
	assign add_a = add_sub ? sample_q : sq_y;
	assign add_b = add_sub ? golden_q : status.sum;

	assign sq_start = (state == st_square);
	assign sq_a = add_y;    // difference held by the adder

	assign acc_load = (state == st_wait_acc) && add_ready;
	assign acc_value = add_y;

endmodule

// File: hdl/sse_top.sv
module sse_top
	import fp_pkg::*, sse_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        clear,
	input  logic        sample_valid,
	input  fp32_t       sample,
	input  fp32_t       golden,
	output logic        busy,
	output logic        ready,
	output acc_status_t status
);

	logic add_start, add_sub, add_ready;
	fp32_t add_a, add_b, add_y;
	logic sq_start, sq_ready;
	fp32_t sq_a, sq_y;
	logic acc_load;
	fp32_t acc_value;

	sse_sequencer i_seq (
		.clk          (clk),
		.rst          (rst),
		.sample_valid (sample_valid),
		.sample       (sample),
		.golden       (golden),
		.status       (status),
		.add_start    (add_start),
		.add_sub      (add_sub),
		.add_a        (add_a),
		.add_b        (add_b),
		.add_ready    (add_ready),
		.add_y        (add_y),
		.sq_start     (sq_start),
		.sq_a         (sq_a),
		.sq_ready     (sq_ready),
		.sq_y         (sq_y),
		.acc_load     (acc_load),
		.acc_value    (acc_value),
		.busy         (busy),
		.ready        (ready)
	);

	// shared by the subtract and the accumulate step
	fp_add_sub i_add (
		.clk   (clk),
		.rst   (rst),
		.start (add_start),
		.sub   (add_sub),
		.a     (add_a),
		.b     (add_b),
		.busy  (),
		.ready (add_ready),
		.y     (add_y)
	);

	fp_square i_sq (
		.clk   (clk),
		.rst   (rst),
		.start (sq_start),
		.a     (sq_a),
		.busy  (),
		.ready (sq_ready),
		.y     (sq_y)
	);

	sse_accum_regs i_acc (
		.clk       (clk),
		.rst       (rst),
		.clear     (clear),    // only pulsed while idle
		.acc_load  (acc_load),
		.acc_value (acc_value),
		.status    (status)
	);

endmodule

// File: include/sse_defines.svh
`ifndef SSE_DEFINES_SVH
`define SSE_DEFINES_SVH

// single precision layout
`define FP_EXP_W   8
`define FP_FRAC_W  23
`define FP_BIAS    127
`define FP_EXP_MAX 255    // all-ones exponent of inf and nan

// every nan result uses this word
`define FP_QNAN 32'h7fc00000

// accumulated sample count
`define SSE_CNT_W 16

`endif

// File: verification/sse_assert.sv
module sse_assert (
	input logic clk,
	input logic rst,
	input logic sample_valid,
	input logic busy,
	input logic ready
);

	timeunit 1ns;
	timeprecision 1ps;

	// ready is a single cycle pulse
	ready_one_cycle: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else $error("ready stayed high for more than one cycle");

	ready_not_busy: assert property (@(posedge clk) disable iff (rst) ready |-> !busy)
		else $error("busy still high while ready pulses");

	// the unit comes out of reset idle
	idle_after_reset: assert property (@(posedge clk) rst |=> !busy)
		else $error("busy high right after reset");

	sample_starts_busy: assert property (@(posedge clk) disable iff (rst)
		(sample_valid && !busy) |=> busy)
		else $error("busy did not rise after an accepted sample_valid");

	busy_ends_with_ready: assert property (@(posedge clk) disable iff (rst)
		$fell(busy) |-> ready)
		else $error("busy fell without a ready pulse");

endmodule

bind sse_top sse_assert i_assert (
	.clk          (clk),
	.rst          (rst),
	.sample_valid (sample_valid),
	.busy         (busy),
	.ready        (ready)
);

// File: verification/sse_tb.sv
`include "sse_defines.svh"

module sse_tb
	import fp_pkg::*, sse_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_rows = 16;
	localparam int ready_timeout = 200;    // cycles
	localparam logic [31:0] qnan = `FP_QNAN;

	typedef enum logic {
		op_sample,
		op_clear
	} op_t;

	// one stimulus row and the state expected after it
	typedef struct packed {
		op_t                   op;
		logic [31:0]           sample;
		logic [31:0]           golden;
		logic [31:0]           sum;
		logic [`SSE_CNT_W-1:0] count;
	} row_t;

	logic clk;
	logic rst;
	logic clear;
	logic sample_valid;
	fp32_t sample;
	fp32_t golden;
	logic busy;
	logic ready;
	acc_status_t status;

	row_t table_rows [n_rows];
	logic [31:0] lfsr;

	sse_top i_dut (
		.clk          (clk),
		.rst          (rst),
		.clear        (clear),
		.sample_valid (sample_valid),
		.sample       (sample),
		.golden       (golden),
		.busy         (busy),
		.ready        (ready),
		.status       (status)
	);

	always #20 clk = ~clk;    // 40 ns period

	function automatic row_t make_row(op_t op, logic [31:0] s, logic [31:0] g,
			logic [31:0] sum, logic [`SSE_CNT_W-1:0] count);
		row_t r;
		r.op = op;
		r.sample = s;
		r.golden = g;
		r.sum = sum;
		r.count = count;
		return r;
	endfunction

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic draw_gap(output int cycles);
		logic [2:0] bits;
		bits = '0;
		for (int i = 0; i < 3; i++) begin
			bits = {bits[1:0], lfsr[0]};    // one step per bit taken
			lfsr = lfsr_step(lfsr);
		end
		cycles = int'(bits);
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
			fail_run($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
				$time, name, got, expected));
	endtask

	task automatic check_status(input row_t r, input int idx);
		check_value($sformatf("status.sum (row %0d)", idx), status.sum.bits, r.sum);
		check_value($sformatf("status.count (row %0d)", idx),
			32'(status.count), 32'(r.count));
	endtask

	task automatic apply_sample(input row_t r);
		logic got_ready;
		int waited;
		@(posedge clk);
		sample_valid <= 1'b1;
		sample.bits <= r.sample;
		golden.bits <= r.golden;
		@(posedge clk);
		sample_valid <= 1'b0;
		got_ready = 1'b0;
		waited = 0;
		while (!got_ready && waited < ready_timeout) begin
			@(posedge clk);
			got_ready = ready;    // value of the cycle just ended
			waited++;
		end
		if (!got_ready)
			fail_run("timeout: no ready pulse within 200 cycles after sample_valid");
	endtask

	task automatic apply_clear();
		@(posedge clk);
		check_value("busy", 32'(busy), 32'd0);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
		@(posedge clk);    // registers zeroed on the previous edge
	endtask

	task automatic load_table();
		// accumulation of plain squares
		table_rows[0] = make_row(op_sample, 32'h40400000, 32'h3f800000, 32'h40800000, 16'd1);
		table_rows[1] = make_row(op_sample, 32'h3f000000, 32'h40000000, 32'h40c80000, 16'd2);
		table_rows[2] = make_row(op_sample, 32'h3f800000, 32'h3f800000, 32'h40c80000, 16'd3);
		table_rows[3] = make_row(op_clear, 32'h0, 32'h0, 32'h0, 16'd0);
		// 1 + 2^-11 + 2^-24 is a tie that stays even
		table_rows[4] = make_row(op_sample, 32'h3f800800, 32'h00000000, 32'h3f801000, 16'd1);
		table_rows[5] = make_row(op_sample, 32'h7f800000, 32'h3f800000, 32'h7f800000, 16'd2);
		table_rows[6] = make_row(op_clear, 32'h0, 32'h0, 32'h0, 16'd0);
		table_rows[7] = make_row(op_sample, 32'h7149f2ca, 32'h00000000, 32'h7f800000, 16'd1);
		table_rows[8] = make_row(op_sample, 32'h7f800000, 32'h7f800000, qnan, 16'd2);
		table_rows[9] = make_row(op_sample, 32'h3f800000, 32'h3f800000, qnan, 16'd3);
		table_rows[10] = make_row(op_clear, 32'h0, 32'h0, 32'h0, 16'd0);
		table_rows[11] = make_row(op_sample, 32'h40000000, 32'h7fa00000, qnan, 16'd1);
		table_rows[12] = make_row(op_sample, 32'h40400000, 32'h3f800000, qnan, 16'd2);
		table_rows[13] = make_row(op_clear, 32'h0, 32'h0, 32'h0, 16'd0);
		table_rows[14] = make_row(op_sample, 32'h40000000, 32'h3f000000, 32'h40100000, 16'd1);
		// subnormal sample counts as zero
		table_rows[15] = make_row(op_sample, 32'h00400000, 32'h00000000, 32'h40100000, 16'd2);
	endtask

	initial begin
		int gap;
		clk = 1'b0;
		rst = 1'b1;
		clear = 1'b0;
		sample_valid = 1'b0;
		sample.bits = '0;
		golden.bits = '0;
		lfsr = 32'h1e63;
		load_table();

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_value("busy", 32'(busy), 32'd0);
		check_value("status.sum after reset", status.sum.bits, 32'h0);
		check_value("status.count after reset", 32'(status.count), 32'd0);

		for (int i = 0; i < n_rows; i++) begin
			draw_gap(gap);
			repeat (gap) @(posedge clk);
			if (table_rows[i].op == op_clear)
				apply_clear();
			else
				apply_sample(table_rows[i]);
			check_status(table_rows[i], i);
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
hdl/fp_pkg.sv
hdl/sse_pkg.sv
hdl/fp_add_sub.sv
hdl/fp_square.sv
hdl/sse_sequencer.sv
hdl/sse_accum_regs.sv
hdl/sse_top.sv
verification/sse_assert.sv
verification/sse_tb.sv
